/* files.f */
src/pipe_pkg.sv
src/dcache_pkg.sv
src/stage_register.sv
src/result_select.sv
src/dcache_request.sv
src/premem_stage.sv
tb/tb_clock_gen.sv
tb/premem_tb.sv

/* Bender.yml */
package:
  name: premem_stage

sources:
  - src/pipe_pkg.sv
  - src/dcache_pkg.sv
  - src/stage_register.sv
  - src/result_select.sv
  - src/dcache_request.sv
  - src/premem_stage.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/premem_tb.sv

/* tb/premem_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module premem_tb;

    localparam int INDEX_W        = 12;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int RESET_TIMEOUT  = 40;

    // stall sources a row can hold during its entry
    localparam logic [1:0] STALL_NONE  = 2'd0;
    localparam logic [1:0] STALL_INDEX = 2'd1;
    localparam logic [1:0] STALL_DOWN  = 2'd2;
    localparam logic [1:0] STALL_SBA   = 2'd3;

    localparam pipe_pkg::fwd_mode_t MODE_EXE = 2'b01;  // forward from this stage
    localparam pipe_pkg::fwd_mode_t MODE_MEM = 2'b11;  // also wait for write-back

    typedef struct packed {
        pipe_pkg::exe_entry_t  entry;
        logic [1:0]            stall_kind;
        logic [3:0]            stall_cycles;
        logic                  flush;
        pipe_pkg::word_t       exp_fwd_data;
        pipe_pkg::fwd_mode_t   exp_fwd_mode;
        dcache_pkg::acc_size_t exp_size;
        logic [INDEX_W-1:0]    exp_index;
        logic                  exp_req;
        logic                  exp_valid;
    } row_t;

    logic                  clk;
    logic                  reset;
    logic                  exe_valid_i;
    pipe_pkg::exe_entry_t  exe_entry_i;
    logic                  allowin_o;
    logic                  down_allowin_i;
    logic                  valid_o;
    pipe_pkg::mem_entry_t  mem_entry_o;
    pipe_pkg::word_t       fwd_data_o;
    pipe_pkg::fwd_mode_t   fwd_mode_o;
    pipe_pkg::gpr_num_t    fwd_write_num_o;
    logic                  sba_risk_i;
    logic                  flush_i;
    logic                  dcache_index_ok_i;
    logic                  dcache_req_o;
    logic [INDEX_W-1:0]    dcache_index_o;
    dcache_pkg::dreq_t     dreq_o;

    integer seed;
    row_t   rows[$];

    tb_clock_gen #(
        .HALF_PERIOD  (5),
        .RESET_CYCLES (16)
    ) i_tb_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    premem_stage #(
        .INDEX_W (INDEX_W)
    ) i_premem_stage (
        .clk               (clk),
        .reset_i           (reset),
        .exe_valid_i       (exe_valid_i),
        .exe_entry_i       (exe_entry_i),
        .allowin_o         (allowin_o),
        .down_allowin_i    (down_allowin_i),
        .valid_o           (valid_o),
        .mem_entry_o       (mem_entry_o),
        .fwd_data_o        (fwd_data_o),
        .fwd_mode_o        (fwd_mode_o),
        .fwd_write_num_o   (fwd_write_num_o),
        .sba_risk_i        (sba_risk_i),
        .flush_i           (flush_i),
        .dcache_index_ok_i (dcache_index_ok_i),
        .dcache_req_o      (dcache_req_o),
        .dcache_index_o    (dcache_index_o),
        .dreq_o            (dreq_o)
    );

    ////////////////////
    // helpers
    ////////////////////

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1, "wait timed out");
    endtask

    // memory fields cleared, strobes full
    function automatic pipe_pkg::exe_entry_t random_entry();
        pipe_pkg::exe_entry_t e;
        e            = '0;
        e.write_num  = $random(seed);
        e.alu_res    = $random(seed);
        e.mul_res    = $random(seed);
        e.mdu_res    = $random(seed);
        e.cl_res     = $random(seed);
        e.store_data = $random(seed);
        e.load_sel   = $random(seed);
        e.mem_strb   = 4'b1111;
        e.math_sel   = pipe_pkg::MATH_NONE;
        return e;
    endfunction

    task automatic add_row(input pipe_pkg::exe_entry_t e, input logic [1:0] kind,
                           input int cycles, input logic flush,
                           input pipe_pkg::word_t exp_fwd, input pipe_pkg::fwd_mode_t exp_mode,
                           input dcache_pkg::acc_size_t exp_size, input logic exp_req,
                           input logic exp_valid);
        row_t r;
        r.entry        = e;
        r.stall_kind   = kind;
        r.stall_cycles = cycles[3:0];
        r.flush        = flush;
        r.exp_fwd_data = exp_fwd;
        r.exp_fwd_mode = exp_mode;
        r.exp_size     = exp_size;
        r.exp_index    = e.alu_res[INDEX_W-1:0];  // index is the low address bits
        r.exp_req      = exp_req;
        r.exp_valid    = exp_valid;
        rows.push_back(r);
    endtask

    task automatic apply_stall(input logic [1:0] kind, input logic on);
        down_allowin_i    = !(on && kind == STALL_DOWN);
        dcache_index_ok_i = !(on && kind == STALL_INDEX);
        sba_risk_i        = on && kind == STALL_SBA;
    endtask

    task automatic wait_allowin();
        int waited;
        waited = 0;
        while (!allowin_o) begin
            if (waited >= TIMEOUT_CYCLES) begin
                timeout_abort("allowin_o never went high");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // fields that hold as long as the entry sits in the stage
    task automatic check_held(input row_t r);
        check_value("fwd_data_o", fwd_data_o, r.exp_fwd_data);
        check_value("mem_entry_o.result", mem_entry_o.result, r.exp_fwd_data);
        check_value("fwd_mode_o", fwd_mode_o, r.exp_fwd_mode);
        check_value("fwd_write_num_o", fwd_write_num_o, r.entry.write_num);
        check_value("mem_entry_o.write_num", mem_entry_o.write_num, r.entry.write_num);
        check_value("mem_entry_o.mem_req", mem_entry_o.mem_req, r.entry.mem_req);
        check_value("mem_entry_o.load_sel", mem_entry_o.load_sel, r.entry.load_sel);
        check_value("mem_entry_o.align", mem_entry_o.align, r.entry.alu_res[1:0]);
        check_value("mem_entry_o.store_data", mem_entry_o.store_data, r.entry.store_data);
        check_value("dcache_index_o", dcache_index_o, r.exp_index);
        check_value("dreq_o.size", dreq_o.size, r.exp_size);
        check_value("dreq_o.wr", dreq_o.wr, r.entry.mem_wr);
        check_value("dreq_o.strb", dreq_o.strb, r.entry.mem_strb);
        check_value("dreq_o.wdata", dreq_o.wdata, r.entry.store_data);
    endtask

    task automatic run_row(input row_t r);
        int   waited;
        logic stall_req;
        waited    = 0;
        stall_req = r.entry.mem_req && r.stall_kind == STALL_INDEX;
        wait_allowin();
        exe_valid_i = 1'b1;
        exe_entry_i = r.entry;
        apply_stall(r.stall_kind, r.stall_cycles != 0);
        @(negedge clk);
        check_held(r);
        if (r.flush) begin
            check_value("valid_o before flush", valid_o, 1'b0);
            check_value("dcache_req_o before flush", dcache_req_o, stall_req);
            exe_valid_i = 1'b0;
            exe_entry_i = '0;
            flush_i     = 1'b1;
            @(negedge clk);
            check_value("valid_o after flush", valid_o, r.exp_valid);
            check_value("dcache_req_o after flush", dcache_req_o, r.exp_req);
            check_value("allowin_o after flush", allowin_o, 1'b1);
            flush_i = 1'b0;
            apply_stall(r.stall_kind, 1'b0);
        end else begin
            while (!valid_o) begin
                if (waited >= TIMEOUT_CYCLES) begin
                    timeout_abort("valid_o never went high");
                end
                check_value("allowin_o during stall", allowin_o, 1'b0);
                check_value("dcache_req_o during stall", dcache_req_o, stall_req);
                check_held(r);
                exe_valid_i = 1'b0;
                exe_entry_i = '0;
                waited++;
                if (waited == int'(r.stall_cycles)) begin
                    // valid_o follows the release before the next rising edge
                    apply_stall(r.stall_kind, 1'b0);
                    #1;
                end else begin
                    @(negedge clk);
                end
            end
            check_value("stall length", waited, r.stall_cycles);
            check_value("valid_o", valid_o, r.exp_valid);
            check_value("dcache_req_o", dcache_req_o, r.exp_req);
            check_value("allowin_o", allowin_o, 1'b1);
            check_held(r);
            exe_valid_i = 1'b0;   // entry leaves on the next edge
            exe_entry_i = '0;
        end
        @(negedge clk);
    endtask

    ////////////////////
    // stimulus table
    ////////////////////

    task automatic build_rows();
        pipe_pkg::exe_entry_t e;
        e = random_entry();
        e.math_sel = pipe_pkg::MATH_ALU;
        add_row(e, STALL_NONE, 0, 1'b0, e.alu_res, MODE_EXE, dcache_pkg::SIZE_WORD, 1'b0, 1'b1);
        e = random_entry();
        e.math_sel = pipe_pkg::MATH_MUL;
        add_row(e, STALL_DOWN, 2, 1'b0, e.mul_res, MODE_EXE, dcache_pkg::SIZE_WORD, 1'b0, 1'b1);
        e = random_entry();
        e.math_sel = pipe_pkg::MATH_CL;
        add_row(e, STALL_NONE, 0, 1'b0, {27'd0, e.cl_res}, MODE_EXE, dcache_pkg::SIZE_WORD,
                1'b0, 1'b1);
        e = random_entry();
        e.math_sel = pipe_pkg::MATH_MDU;
        add_row(e, STALL_NONE, 0, 1'b0, e.mdu_res, MODE_EXE, dcache_pkg::SIZE_WORD, 1'b0, 1'b1);
        e = random_entry();
        add_row(e, STALL_NONE, 0, 1'b0, 32'd0, MODE_EXE, dcache_pkg::SIZE_WORD, 1'b0, 1'b1);

        // stores of each size, two of them held back
        e = random_entry();
        e.math_sel = pipe_pkg::MATH_ALU;
        e.mem_req  = 1'b1;
        e.mem_wr   = 1'b1;
        e.mem_strb = 4'b0001;
        add_row(e, STALL_INDEX, 3, 1'b0, e.alu_res, MODE_MEM, dcache_pkg::SIZE_BYTE, 1'b1, 1'b1);
        e.alu_res  = $random(seed);
        e.mem_strb = 4'b1100;
        add_row(e, STALL_SBA, 2, 1'b0, e.alu_res, MODE_MEM, dcache_pkg::SIZE_HALF, 1'b1, 1'b1);
        e.alu_res  = $random(seed);
        e.mem_strb = 4'b1111;
        add_row(e, STALL_NONE, 0, 1'b0, e.alu_res, MODE_MEM, dcache_pkg::SIZE_WORD, 1'b1, 1'b1);

        // plain load
        e = random_entry();
        e.mem_req = 1'b1;
        add_row(e, STALL_DOWN, 1, 1'b0, 32'd0, MODE_MEM, dcache_pkg::SIZE_WORD, 1'b1, 1'b1);

        // sc before ll, ll, sc after ll, eret, sc after eret
        e = random_entry();
        e.mem_req  = 1'b1;
        e.mem_wr   = 1'b1;
        e.mem_atom = 1'b1;
        add_row(e, STALL_NONE, 0, 1'b0, 32'd0, MODE_MEM, dcache_pkg::SIZE_WORD, 1'b1, 1'b1);
        e = random_entry();
        e.mem_req  = 1'b1;
        e.mem_atom = 1'b1;
        add_row(e, STALL_INDEX, 2, 1'b0, 32'd0, MODE_MEM, dcache_pkg::SIZE_WORD, 1'b1, 1'b1);
        e = random_entry();
        e.mem_req  = 1'b1;
        e.mem_wr   = 1'b1;
        e.mem_atom = 1'b1;
        add_row(e, STALL_DOWN, 2, 1'b0, 32'd1, MODE_MEM, dcache_pkg::SIZE_WORD, 1'b1, 1'b1);
        e = random_entry();
        e.math_sel = pipe_pkg::MATH_ALU;
        e.eret     = 1'b1;
        add_row(e, STALL_NONE, 0, 1'b0, e.alu_res, MODE_EXE, dcache_pkg::SIZE_WORD, 1'b0, 1'b1);
        e = random_entry();
        e.mem_req  = 1'b1;
        e.mem_wr   = 1'b1;
        e.mem_atom = 1'b1;
        add_row(e, STALL_NONE, 0, 1'b0, 32'd0, MODE_MEM, dcache_pkg::SIZE_WORD, 1'b1, 1'b1);

        // store flushed while the cache refuses the index
        e = random_entry();
        e.math_sel = pipe_pkg::MATH_ALU;
        e.mem_req  = 1'b1;
        e.mem_wr   = 1'b1;
        add_row(e, STALL_INDEX, 3, 1'b1, e.alu_res, MODE_MEM, dcache_pkg::SIZE_WORD, 1'b0, 1'b0);
        e = random_entry();
        e.math_sel = pipe_pkg::MATH_CL;
        add_row(e, STALL_DOWN, 3, 1'b0, {27'd0, e.cl_res}, MODE_EXE, dcache_pkg::SIZE_WORD,
                1'b0, 1'b1);
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int waited;
        exe_valid_i       = 1'b0;
        exe_entry_i       = '0;
        down_allowin_i    = 1'b1;
        dcache_index_ok_i = 1'b1;
        sba_risk_i        = 1'b0;
        flush_i           = 1'b0;
        seed              = 31137;
        build_rows();

        waited = 0;
        @(negedge clk);
        while (reset) begin
            if (waited >= RESET_TIMEOUT) begin
                timeout_abort("reset was never released");
            end
            waited++;
            @(negedge clk);
        end
        check_value("valid_o after reset", valid_o, 1'b0);
        check_value("dcache_req_o after reset", dcache_req_o, 1'b0);
        check_value("allowin_o after reset", allowin_o, 1'b1);

        foreach (rows[i]) begin
            run_row(rows[i]);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // drops right after the last reset edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* src/premem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module premem_stage #(
    parameter int INDEX_W = 12   // 6 to 14
) (
    input  wire                  clk,
    input  wire                  reset_i,

    // execute side
    input  wire                  exe_valid_i,
    input  pipe_pkg::exe_entry_t exe_entry_i,
    output logic                 allowin_o,

    // memory side
    input  wire                  down_allowin_i,
    output logic                 valid_o,
    output pipe_pkg::mem_entry_t mem_entry_o,

    // forwarding to decode
    output pipe_pkg::word_t      fwd_data_o,
    output pipe_pkg::fwd_mode_t  fwd_mode_o,
    output pipe_pkg::gpr_num_t   fwd_write_num_o,

    // stall and flush
    input  wire                  sba_risk_i,
    input  wire                  flush_i,

    // data cache, first step
    input  wire                  dcache_index_ok_i,
    output logic                 dcache_req_o,
    output logic [INDEX_W-1:0]   dcache_index_o,
    output dcache_pkg::dreq_t    dreq_o
);

    pipe_pkg::exe_entry_t held;
    pipe_pkg::word_t      result;
    logic                 has_data;
    logic                 ready;

    stage_register i_stage_register (
        .clk            (clk),
        .reset_i        (reset_i),
        .exe_valid_i    (exe_valid_i),
        .exe_entry_i    (exe_entry_i),
        .allowin_o      (allowin_o),
        .ready_i        (ready),
        .down_allowin_i (down_allowin_i),
        .flush_i        (flush_i),
        .valid_o        (valid_o),
        .has_data_o     (has_data),
        .entry_o        (held)
    );

    result_select i_result_select (
        .clk         (clk),
        .reset_i     (reset_i),
        .entry_i     (held),
        .result_o    (result),
        .fwd_mode_o  (fwd_mode_o),
        .write_num_o (fwd_write_num_o)
    );

    dcache_request #(
        .INDEX_W (INDEX_W)
    ) i_dcache_request (
        .entry_i           (held),
        .sba_risk_i        (sba_risk_i),
        .down_allowin_i    (down_allowin_i),
        .dcache_index_ok_i (dcache_index_ok_i),
        .dcache_req_o      (dcache_req_o),
        .dcache_index_o    (dcache_index_o),
        .dreq_o            (dreq_o),
        .ready_o           (ready)
    );

    assign fwd_data_o = result;

    ////////////////////
    // to memory stage
    ////////////////////

    always_comb begin
        mem_entry_o.write_num  = held.write_num;
        mem_entry_o.result     = result;
        mem_entry_o.mem_req    = held.mem_req && has_data;  // only a live entry waits on data
        mem_entry_o.load_sel   = held.load_sel;
        mem_entry_o.align      = held.alu_res[1:0];
        mem_entry_o.store_data = held.store_data;
    end

endmodule

`default_nettype wire

/* src/dcache_request.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_request #(
    parameter int INDEX_W = 12
) (
    input  pipe_pkg::exe_entry_t entry_i,
    input  wire                  sba_risk_i,        // store buffer hazard
    input  wire                  down_allowin_i,
    input  wire                  dcache_index_ok_i,
    output logic                 dcache_req_o,
    output logic [INDEX_W-1:0]   dcache_index_o,
    output dcache_pkg::dreq_t    dreq_o,
    output logic                 ready_o
);

    logic [2:0]            strb_cnt;
    dcache_pkg::acc_size_t size;
    logic                  store_conflict;
    logic                  index_refused;

    ////////////////////
    // access size
    ////////////////////

    // number of enabled byte lanes
    assign strb_cnt = {2'b00, entry_i.mem_strb[0]} + {2'b00, entry_i.mem_strb[1]}
                    + {2'b00, entry_i.mem_strb[2]} + {2'b00, entry_i.mem_strb[3]};

    always_comb begin
        case (strb_cnt)
            3'd1:    size = dcache_pkg::SIZE_BYTE;
            3'd2:    size = dcache_pkg::SIZE_HALF;
            default: size = dcache_pkg::SIZE_WORD;
        endcase
    end

    ////////////////////
    // request
    ////////////////////

    assign dcache_req_o   = entry_i.mem_req && !sba_risk_i && down_allowin_i;
    assign dcache_index_o = entry_i.alu_res[INDEX_W-1:0];  // untranslated low bits

    always_comb begin
        dreq_o.wr    = entry_i.mem_wr;
        dreq_o.strb  = entry_i.mem_strb;
        dreq_o.size  = size;
        dreq_o.wdata = entry_i.store_data;
    end

    // stall causes
    assign store_conflict = entry_i.mem_req && sba_risk_i;
    assign index_refused  = entry_i.mem_req && !dcache_index_ok_i;

    assign ready_o = !(store_conflict || index_refused);

endmodule

`default_nettype wire

/* src/result_select.sv */
`timescale 1ns/1ns
`default_nettype none

module result_select (
    input  wire                  clk,
    input  wire                  reset_i,
    input  pipe_pkg::exe_entry_t entry_i,
    output pipe_pkg::word_t      result_o,
    output pipe_pkg::fwd_mode_t  fwd_mode_o,
    output pipe_pkg::gpr_num_t   write_num_o
);

    logic is_ll;
    logic is_sc;
    logic link_q;

    // atomic access decode
    assign is_ll = entry_i.mem_req && !entry_i.mem_wr && entry_i.mem_atom;
    assign is_sc = entry_i.mem_req &&  entry_i.mem_wr && entry_i.mem_atom;

    ////////////////////
    // link bit
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset_i || entry_i.eret) begin
            link_q <= 1'b0;
        end else if (is_ll) begin
            link_q <= 1'b1;
        end
    end

    ////////////////////
    // result mux
    ////////////////////

    always_comb begin
        case (entry_i.math_sel)
            pipe_pkg::MATH_ALU: result_o = entry_i.alu_res;
            pipe_pkg::MATH_MUL: result_o = entry_i.mul_res;
            pipe_pkg::MATH_MDU: result_o = entry_i.mdu_res;
            pipe_pkg::MATH_CL:  result_o = {{(32 - pipe_pkg::CL_W){1'b0}}, entry_i.cl_res};
            default:            result_o = '0;
        endcase
        // sc writes back success flag
        if (is_sc) begin
            result_o = {31'b0, link_q};
        end
    end

    // loads only have their data at write-back
    always_comb begin
        fwd_mode_o                   = '0;
        fwd_mode_o[pipe_pkg::FWD_MEM] = 1'b1;
        fwd_mode_o[pipe_pkg::FWD_WB]  = entry_i.mem_req;
    end

    assign write_num_o = entry_i.write_num;

endmodule

`default_nettype wire

/* src/stage_register.sv */
`timescale 1ns/1ns
`default_nettype none

module stage_register (
    input  wire                  clk,
    input  wire                  reset_i,

    // from execute
    input  wire                  exe_valid_i,
    input  pipe_pkg::exe_entry_t exe_entry_i,
    output logic                 allowin_o,

    // stall and flush
    input  wire                  ready_i,         // low while cache or sba stalls
    input  wire                  down_allowin_i,
    input  wire                  flush_i,

    // toward memory and the sibling blocks
    output logic                 valid_o,
    output logic                 has_data_o,
    output pipe_pkg::exe_entry_t entry_o
);

    pipe_pkg::exe_entry_t entry_q;
    logic                 has_data_q;
    logic                 advance;

    ////////////////////
    // interlock
    ////////////////////

    // an empty stage always takes a new entry
    assign allowin_o = !has_data_q || (ready_i && down_allowin_i);
    assign valid_o   = has_data_q && ready_i && down_allowin_i;
    assign advance   = allowin_o;

    ////////////////////
    // entry register
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            entry_q    <= '0;
            has_data_q <= 1'b0;
        end else if (advance) begin
            if (exe_valid_i) begin
                entry_q    <= exe_entry_i;
                has_data_q <= 1'b1;
            end else begin
                // bubble, zero entry keeps downstream logic quiet
                entry_q    <= '0;
                has_data_q <= 1'b0;
            end
        end
    end

    assign entry_o    = entry_q;
    assign has_data_o = has_data_q;

endmodule

`default_nettype wire

/* src/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    typedef logic [3:0] strb_t;  // one bit per byte lane

    // encoding as the cache expects it
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b11
    } acc_size_t;

    // first step of a cache access, index travels beside it
    typedef struct packed {
        logic            wr;
        strb_t           strb;
        acc_size_t       size;
        pipe_pkg::word_t wdata;
    } dreq_t;

endpackage

`default_nettype wire

/* src/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // width of the count-leading result
    localparam int CL_W = 5;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  gpr_num_t;   // zero means no write-back
    typedef logic [2:0]  load_sel_t;  // opaque here, decoded in memory stage
    typedef logic [1:0]  fwd_mode_t;

    // bit positions inside fwd_mode_t
    localparam int FWD_MEM = 0;  // result usable from this stage
    localparam int FWD_WB  = 1;  // result only at write-back

    typedef enum logic [2:0] {
        MATH_NONE = 3'd0,
        MATH_ALU  = 3'd1,
        MATH_MUL  = 3'd2,
        MATH_CL   = 3'd3,
        MATH_MDU  = 3'd4   // hi/lo move
    } math_sel_t;

    // everything latched from execute
    typedef struct packed {
        gpr_num_t         write_num;
        word_t            alu_res;     // also the memory address
        word_t            mul_res;
        word_t            mdu_res;
        logic [CL_W-1:0]  cl_res;
        math_sel_t        math_sel;
        logic             mem_req;
        logic             mem_wr;
        logic             mem_atom;    // ll / sc
        logic [3:0]       mem_strb;
        word_t            store_data;
        load_sel_t        load_sel;
        logic             eret;
    } exe_entry_t;

    // handed on to the memory stage
    typedef struct packed {
        gpr_num_t   write_num;
        word_t      result;
        logic       mem_req;
        load_sel_t  load_sel;
        logic [1:0] align;       // low address bits
        word_t      store_data;
    } mem_entry_t;

endpackage

`default_nettype wire
